// File: src/soc_bus_pkg.sv
package soc_bus_pkg;

   ////////////////////////////////////////////////////////////
   // native bus widths
   ////////////////////////////////////////////////////////////

   // byte address, top bit picks the region
   parameter int ADDR_W = 16;

   // one bus word
   parameter int DATA_W = 32;

   ////////////////////////////////////////////////////////////
   // bus field types
   ////////////////////////////////////////////////////////////

   typedef logic [ADDR_W-1:0] addr_t;

   typedef logic [DATA_W-1:0] data_t;

   // one bit per byte lane, all zero on a read
   typedef logic [DATA_W/8-1:0] strb_t;

   // serial character
   typedef logic [7:0] byte_t;

endpackage

// File: src/soc_map_pkg.sv
package soc_map_pkg;

   ////////////////////////////////////////////////////////////
   // region decode
   ////////////////////////////////////////////////////////////

   // 0 selects the sram, 1 the uart
   parameter int PERIPH_BIT = soc_bus_pkg::ADDR_W - 1;

   ////////////////////////////////////////////////////////////
   // uart registers
   ////////////////////////////////////////////////////////////

   // word offset, address bits 3:2
   typedef logic [1:0] uart_reg_t;

   parameter uart_reg_t UART_TXDATA = 2'd0;
   parameter uart_reg_t UART_RXDATA = 2'd1;
   parameter uart_reg_t UART_STATUS = 2'd2;
   parameter uart_reg_t UART_DIV    = 2'd3;

   // status word bits
   parameter int STAT_RX_VALID = 0;
   parameter int STAT_TX_BUSY  = 1;

endpackage

// File: src/bus_split.sv
module bus_split (
   // master side
   input  logic                valid,
   input  soc_bus_pkg::addr_t  address,
   output soc_bus_pkg::data_t  rdata,
   output logic                ready,

   // internal memory
   output logic                mem_valid,
   input  soc_bus_pkg::data_t  mem_rdata,
   input  logic                mem_ready,

   // uart
   output logic                uart_valid,
   input  soc_bus_pkg::data_t  uart_rdata,
   input  logic                uart_ready
);

   ////////////////////////////////////////////////////////////
   // region decode
   ////////////////////////////////////////////////////////////

   logic periph_sel;

   // request fields are held until ready, so the
   // select stays put for the whole transaction
   assign periph_sel = address[soc_map_pkg::PERIPH_BIT];

   ////////////////////////////////////////////////////////////
   // request steering
   ////////////////////////////////////////////////////////////

   // only one slave ever sees valid
   assign mem_valid  = valid & ~periph_sel;
   assign uart_valid = valid & periph_sel;

   ////////////////////////////////////////////////////////////
   // response return
   ////////////////////////////////////////////////////////////

   always_comb begin
      if (periph_sel) begin
         rdata = uart_rdata;
         ready = uart_ready;
      end else begin
         rdata = mem_rdata;
         ready = mem_ready;
      end
   end

endmodule

// File: src/int_mem.sv
module int_mem #(
   parameter int MEM_ADDR_W = 8
) (
   input  logic                clk,
   input  logic                reset,

   input  logic                valid,
   input  soc_bus_pkg::addr_t  address,
   input  soc_bus_pkg::data_t  wdata,
   input  soc_bus_pkg::strb_t  wstrb,
   output soc_bus_pkg::data_t  rdata,
   output logic                ready
);

   localparam int DEPTH  = 2 ** MEM_ADDR_W;
   localparam int LANE_N = $bits(soc_bus_pkg::strb_t);

   soc_bus_pkg::data_t    mem [0:DEPTH-1];
   logic [MEM_ADDR_W-1:0] word_idx;
   logic                  access;

   // byte address to word index
   assign word_idx = address[MEM_ADDR_W+1:2];

   // served once, ready drops the cycle after it fires
   assign access = valid & ~ready;

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (access) begin
         for (int i = 0; i < LANE_N; i++) begin
            if (wstrb[i]) begin
               mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
         // old word on a write cycle
         rdata <= mem[word_idx];
      end
   end

   ////////////////////////////////////////////////////////////
   // response strobe
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= access;
      end
   end

endmodule

// File: src/uart_core.sv
module uart_core #(
   parameter logic [15:0] UART_DIV_RESET = 16'd16
) (
   input  logic                clk,
   input  logic                reset,

   input  logic                valid,
   input  soc_bus_pkg::addr_t  address,
   input  soc_bus_pkg::data_t  wdata,
   input  soc_bus_pkg::strb_t  wstrb,
   output soc_bus_pkg::data_t  rdata,
   output logic                ready,

   output logic                txd,
   input  logic                rxd,
   output logic                rts,
   input  logic                cts
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   soc_map_pkg::uart_reg_t reg_sel;
   logic                   is_write, tx_wr, accept, rx_rd;
   logic [15:0]            divisor;
   soc_bus_pkg::data_t     rd_word;

   tx_state_t              tx_state;
   soc_bus_pkg::byte_t     hold_data, tx_shift;
   logic                   hold_full, tx_take, tx_tick, tx_busy;
   logic [15:0]            tx_cnt;
   logic [2:0]             tx_bit;

   rx_state_t              rx_state;
   soc_bus_pkg::byte_t     rx_shift, rx_buf;
   logic [1:0]             rx_sync;
   logic                   rx_in, rx_tick, rx_half, rx_valid;
   logic [15:0]            rx_cnt;
   logic [2:0]             rx_bit;

   ////////////////////////////////////////////////////////////
   // register access
   ////////////////////////////////////////////////////////////

   assign reg_sel  = address[3:2];
   assign is_write = |wstrb;
   assign tx_wr    = is_write && (reg_sel == soc_map_pkg::UART_TXDATA);
   assign rx_rd    = accept && !is_write && (reg_sel == soc_map_pkg::UART_RXDATA);

   // tx write stalls while the holding register is full
   assign accept = valid && !ready && !(tx_wr && hold_full);

   always_comb begin
      rd_word = '0;
      case (reg_sel)
         soc_map_pkg::UART_RXDATA: rd_word[7:0] = rx_buf;
         soc_map_pkg::UART_STATUS: begin
            rd_word[soc_map_pkg::STAT_RX_VALID] = rx_valid;
            rd_word[soc_map_pkg::STAT_TX_BUSY]  = tx_busy;
         end
         soc_map_pkg::UART_DIV:    rd_word[15:0] = divisor;
         default:                  rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ready   <= 1'b0;
         divisor <= UART_DIV_RESET;
      end else begin
         ready <= accept;
         if (accept && is_write && reg_sel == soc_map_pkg::UART_DIV) begin
            divisor <= wdata[15:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata <= rd_word;
      end
   end

   ////////////////////////////////////////////////////////////
   // transmitter, 8N1 lsb first
   ////////////////////////////////////////////////////////////

   // cts only matters when a frame is about to start
   assign tx_take = (tx_state == TX_IDLE) && hold_full && cts;
   assign tx_tick = (tx_cnt == divisor - 16'd1);
   assign tx_busy = hold_full || (tx_state != TX_IDLE);

   always_ff @(posedge clk) begin
      if (reset) begin
         tx_state  <= TX_IDLE;
         hold_full <= 1'b0;
         tx_cnt    <= '0;
         tx_bit    <= '0;
         txd       <= 1'b1;
      end else begin
         if (accept && tx_wr) begin
            hold_full <= 1'b1;
         end
         tx_cnt <= tx_tick ? '0 : tx_cnt + 16'd1;
         case (tx_state)
            TX_IDLE: begin
               tx_cnt <= '0;
               if (tx_take) begin
                  hold_full <= 1'b0;
                  tx_state  <= TX_START;
                  txd       <= 1'b0;
               end
            end
            TX_START: if (tx_tick) begin
               tx_state <= TX_DATA;
               tx_bit   <= '0;
               txd      <= tx_shift[0];
            end
            TX_DATA: if (tx_tick) begin
               if (tx_bit == 3'd7) begin
                  tx_state <= TX_STOP;
                  txd      <= 1'b1;
               end else begin
                  tx_bit <= tx_bit + 3'd1;
                  txd    <= tx_shift[1];
               end
            end
            default: if (tx_tick) begin
               tx_state <= TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept && tx_wr) begin
         hold_data <= wdata[7:0];
      end
      if (tx_take) begin
         tx_shift <= hold_data;
      end else if (tx_state == TX_DATA && tx_tick) begin
         tx_shift <= tx_shift >> 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // receiver, sampled at mid bit
   ////////////////////////////////////////////////////////////

   assign rx_in   = rx_sync[1];
   assign rx_tick = (rx_cnt == divisor - 16'd1);
   assign rx_half = (rx_cnt == (divisor >> 1) - 16'd1);

   // empty buffer lets the far end send
   assign rts = ~rx_valid;

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_sync  <= 2'b11;
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], rxd};
         rx_cnt  <= rx_tick ? '0 : rx_cnt + 16'd1;
         if (rx_rd) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_in) begin
                  rx_state <= RX_START;
               end
            end
            RX_START: if (rx_half) begin
               // realign the counter to mid bit, drop glitches
               rx_cnt   <= '0;
               rx_bit   <= '0;
               rx_state <= rx_in ? RX_IDLE : RX_DATA;
            end
            RX_DATA: if (rx_tick) begin
               rx_bit <= rx_bit + 3'd1;
               if (rx_bit == 3'd7) begin
                  rx_state <= RX_STOP;
               end
            end
            default: if (rx_tick) begin
               rx_state <= RX_IDLE;
               if (rx_in) begin
                  rx_valid <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_state == RX_DATA && rx_tick) begin
         rx_shift <= {rx_in, rx_shift[7:1]};
      end
      if (rx_state == RX_STOP && rx_tick && rx_in) begin
         rx_buf <= rx_shift;
      end
   end

endmodule

// File: src/soc_system.sv
module soc_system #(
   parameter int          MEM_ADDR_W     = 8,
   parameter logic [15:0] UART_DIV_RESET = 16'd16
) (
   input  logic                clk,
   input  logic                reset,

   // processor bus
   input  logic                valid,
   input  soc_bus_pkg::addr_t  address,
   input  soc_bus_pkg::data_t  wdata,
   input  soc_bus_pkg::strb_t  wstrb,
   output soc_bus_pkg::data_t  rdata,
   output logic                ready,

   // serial port
   output logic                txd,
   input  logic                rxd,
   output logic                rts,
   input  logic                cts
);

   logic               mem_valid, mem_ready;
   logic               uart_valid, uart_ready;
   soc_bus_pkg::data_t mem_rdata, uart_rdata;

   ////////////////////////////////////////////////////////////
   // memory / peripheral split
   ////////////////////////////////////////////////////////////

   bus_split split0 (
      .valid      (valid),
      .address    (address),
      .rdata      (rdata),
      .ready      (ready),
      .mem_valid  (mem_valid),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready),
      .uart_valid (uart_valid),
      .uart_rdata (uart_rdata),
      .uart_ready (uart_ready)
   );

   ////////////////////////////////////////////////////////////
   // slaves
   ////////////////////////////////////////////////////////////

   int_mem #(.MEM_ADDR_W(MEM_ADDR_W)) int_mem0 (
      .clk     (clk),
      .reset   (reset),
      .valid   (mem_valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (mem_rdata),
      .ready   (mem_ready)
   );

   uart_core #(.UART_DIV_RESET(UART_DIV_RESET)) uart0 (
      .clk     (clk),
      .reset   (reset),
      .valid   (uart_valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (uart_rdata),
      .ready   (uart_ready),
      .txd     (txd),
      .rxd     (rxd),
      .rts     (rts),
      .cts     (cts)
   );

endmodule

// File: tests/soc_system_sva.sv
module soc_system_sva (
   input logic clk,
   input logic reset,
   input logic valid,
   input logic ready,
   input logic txd,
   input logic mem_valid,
   input logic uart_valid
);

   int fail_count = 0;

   ////////////////////////////////////////////////////////////
   // bus handshake
   ////////////////////////////////////////////////////////////

   ready_needs_valid: assert property (@(posedge clk) disable iff (reset) ready |-> valid)
      else begin
         fail_count++;
         $error("ready seen without valid");
      end

   // single cycle response pulse
   ready_one_cycle: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
      else begin
         fail_count++;
         $error("ready high two cycles in a row");
      end

   ////////////////////////////////////////////////////////////
   // decode and serial line
   ////////////////////////////////////////////////////////////

   one_slave_only: assert property (@(posedge clk) !(mem_valid && uart_valid))
      else begin
         fail_count++;
         $error("memory and uart selected together");
      end

   txd_idle_in_reset: assert property (@(posedge clk) reset |=> txd)
      else begin
         fail_count++;
         $error("txd low during reset");
      end

endmodule

bind soc_system soc_system_sva sva0 (
   .clk        (clk),
   .reset      (reset),
   .valid      (valid),
   .ready      (ready),
   .txd        (txd),
   .mem_valid  (mem_valid),
   .uart_valid (uart_valid)
);

// File: tests/soc_checker.sv
module soc_checker #(
   parameter int          MEM_ADDR_W     = 8,
   parameter logic [15:0] UART_DIV_RESET = 16'd16
) (
   input logic                clk,
   input logic                reset,
   input logic                valid,
   input soc_bus_pkg::addr_t  address,
   input soc_bus_pkg::data_t  wdata,
   input soc_bus_pkg::strb_t  wstrb,
   input soc_bus_pkg::data_t  rdata,
   input logic                ready,
   input logic                txd,
   input logic                rts
);

   localparam int DEPTH  = 2 ** MEM_ADDR_W;
   localparam int LANE_N = $bits(soc_bus_pkg::strb_t);

   soc_bus_pkg::data_t model_mem [0:DEPTH-1];
   // bytes written to TXDATA and not yet read back
   soc_bus_pkg::byte_t tx_q [$];
   logic [15:0]        div_model;
   logic               tx_seen;
   int                 lat;
   int                 err_count = 0;
   int                 check_count = 0;

   task automatic report_value(input string name, input soc_bus_pkg::data_t got,
                               input soc_bus_pkg::data_t want);
      err_count++;
      $display("FAIL %s: got %h, expected %h", name, got, want);
   endtask

   task automatic compare_masked(input string name, input soc_bus_pkg::data_t got,
                                 input soc_bus_pkg::data_t want, input soc_bus_pkg::data_t care);
      check_count++;
      if ((got & care) !== (want & care)) begin
         report_value(name, got & care, want & care);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // bus and pin monitor
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin : watch
      logic [MEM_ADDR_W-1:0]  idx;
      soc_map_pkg::uart_reg_t r;
      soc_bus_pkg::data_t     want, care;
      logic                   periph;

      idx    = address[MEM_ADDR_W+1:2];
      r      = address[3:2];
      periph = address[soc_map_pkg::PERIPH_BIT];
      if (reset) begin
         tx_q.delete();
         div_model = UART_DIV_RESET;
         tx_seen   = 1'b0;
         lat       = 0;
      end else begin
         // nothing sent yet, so the line and rts must be idle
         if (!tx_seen && txd !== 1'b1) begin
            report_value("txd", {31'b0, txd}, 32'h1);
         end
         if (!tx_seen && rts !== 1'b1) begin
            report_value("rts", {31'b0, rts}, 32'h1);
         end
         if (valid && !ready) begin
            lat++;
         end
         if (valid && ready) begin
            // a TXDATA write may be held off only while an earlier byte is unread
            if (lat != 1 && !(periph && r == soc_map_pkg::UART_TXDATA && |wstrb
                              && tx_q.size() != 0)) begin
               err_count++;
               $display("ready came %0d cycles after valid at address %h instead of 1",
                        lat, address);
            end
            lat = 0;
            if (!periph) begin
               if (|wstrb) begin
                  for (int i = 0; i < LANE_N; i++) begin
                     if (wstrb[i]) begin
                        model_mem[idx][8*i +: 8] = wdata[8*i +: 8];
                     end
                  end
               end else begin
                  compare_masked("rdata", rdata, model_mem[idx], '1);
               end
            end else if (|wstrb) begin
               if (r == soc_map_pkg::UART_TXDATA) begin
                  tx_q.push_back(wdata[7:0]);
                  tx_seen = 1'b1;
               end else if (r == soc_map_pkg::UART_DIV) begin
                  div_model = wdata[15:0];
               end
            end else begin
               case (r)
                  soc_map_pkg::UART_TXDATA: compare_masked("rdata", rdata, '0, '1);
                  soc_map_pkg::UART_RXDATA: begin
                     if (tx_q.size() == 0) begin
                        err_count++;
                        $display("RXDATA read with no byte sent and unread");
                     end else begin
                        compare_masked("rdata", rdata, {24'b0, tx_q[0]}, '1);
                        tx_q.pop_front();
                     end
                  end
                  soc_map_pkg::UART_STATUS: begin
                     // only the bits fixed by the byte count are compared
                     want = '0;
                     care = ~32'h3;
                     if (!tx_seen) begin
                        care = '1;
                     end else begin
                        if (tx_q.size() == 0) begin
                           care[soc_map_pkg::STAT_RX_VALID] = 1'b1;
                        end
                        // rx buffer holds one and the other is still on the tx side
                        if (tx_q.size() >= 2) begin
                           care[soc_map_pkg::STAT_TX_BUSY] = 1'b1;
                           want[soc_map_pkg::STAT_TX_BUSY] = 1'b1;
                        end
                     end
                     compare_masked("status", rdata, want, care);
                  end
                  default: compare_masked("divisor", rdata, {16'b0, div_model}, '1);
               endcase
            end
         end
      end
   end

endmodule

// File: tests/tb_soc_system.sv
module tb_soc_system;

   localparam int          MEM_ADDR_W   = 8;
   localparam logic [15:0] DIV_RESET    = 16'd16;
   localparam int          FRAME_CYCLES = 10 * 16;
   // memory fill and random ops need about 3k cycles, each frame 160,
   // the polls little more, so 40k is a wide margin
   localparam int          CYCLE_LIMIT  = 40000;

   logic               clk, reset, valid, ready, txd, rts;
   soc_bus_pkg::addr_t address;
   soc_bus_pkg::data_t wdata, rdata, rd_val;
   soc_bus_pkg::strb_t wstrb;
   integer             seed;
   int                 cycle_cnt = 0;
   int                 tests_run = 0;
   int                 tests_failed = 0;
   int                 err_mark = 0;

   // serial loopback, rts feeds cts
   soc_system #(.MEM_ADDR_W(MEM_ADDR_W), .UART_DIV_RESET(DIV_RESET)) UUT (
      .clk (clk), .reset (reset),
      .valid (valid), .address (address), .wdata (wdata), .wstrb (wstrb),
      .rdata (rdata), .ready (ready),
      .txd (txd), .rxd (txd), .rts (rts), .cts (rts)
   );

   soc_checker #(.MEM_ADDR_W(MEM_ADDR_W), .UART_DIV_RESET(DIV_RESET)) chk (
      .clk (clk), .reset (reset),
      .valid (valid), .address (address), .wdata (wdata), .wstrb (wstrb),
      .rdata (rdata), .ready (ready), .txd (txd), .rts (rts)
   );

   ////////////////////////////////////////////////////////////
   // clock and run limit
   ////////////////////////////////////////////////////////////

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("=== FAIL ===");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // bus helpers
   ////////////////////////////////////////////////////////////

   function automatic int total_errors();
      return chk.err_count + UUT.sva0.fail_count;
   endfunction

   function automatic soc_bus_pkg::addr_t uart_addr(input soc_map_pkg::uart_reg_t r);
      soc_bus_pkg::addr_t a;
      a = '0;
      a[soc_map_pkg::PERIPH_BIT] = 1'b1;
      a[3:2] = r;
      return a;
   endfunction

   // hold the request until ready, sample at the falling edge
   task automatic bus_access(input soc_bus_pkg::addr_t a, input soc_bus_pkg::data_t d,
                             input soc_bus_pkg::strb_t s, output soc_bus_pkg::data_t result);
      @(posedge clk);
      #2;
      valid   = 1'b1;
      address = a;
      wdata   = d;
      wstrb   = s;
      @(negedge clk);
      while (ready !== 1'b1) begin
         @(negedge clk);
      end
      result = rdata;
      @(posedge clk);
      #2;
      valid = 1'b0;
      wstrb = '0;
   endtask

   task automatic write_word(input soc_bus_pkg::addr_t a, input soc_bus_pkg::data_t d,
                             input soc_bus_pkg::strb_t s);
      soc_bus_pkg::data_t unused;
      bus_access(a, d, s, unused);
   endtask

   task automatic read_word(input soc_bus_pkg::addr_t a, output soc_bus_pkg::data_t d);
      bus_access(a, '0, '0, d);
   endtask

   task automatic wait_rx_valid();
      soc_bus_pkg::data_t st;
      do begin
         read_word(uart_addr(soc_map_pkg::UART_STATUS), st);
      end while (st[soc_map_pkg::STAT_RX_VALID] !== 1'b1);
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = total_errors() - err_mark;
      tests_run++;
      if (errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errs);
      end
      err_mark = total_errors();
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0]        r;
      logic [15:0]        d;
      soc_bus_pkg::addr_t a;
      soc_bus_pkg::strb_t s;
      soc_bus_pkg::byte_t fc_bytes [3];

      seed    = 32'h85d34a6f;
      reset   = 1'b1;
      valid   = 1'b0;
      address = '0;
      wdata   = '0;
      wstrb   = '0;
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;

      read_word(uart_addr(soc_map_pkg::UART_STATUS), rd_val);
      read_word(uart_addr(soc_map_pkg::UART_DIV), rd_val);
      finish_test("reset");

      // fill every word, pattern from the full byte address
      for (int i = 0; i < 2 ** MEM_ADDR_W; i++) begin
         a = soc_bus_pkg::addr_t'(i * 4);
         write_word(a, {~a, a}, '1);
      end
      repeat (300) begin
         r = $random(seed);
         s = r[19:16];
         if (s == '0) begin
            s = '1;
         end
         write_word({1'b0, r[14:2], 2'b00}, $random(seed), s);
         r = $random(seed);
         read_word({1'b0, r[14:2], 2'b00}, rd_val);
      end
      finish_test("memory");

      repeat (8) begin
         r = $random(seed);
         d = 16'd4 + (r[15:0] % 16'd17);
         write_word(uart_addr(soc_map_pkg::UART_DIV), {16'h0, d}, '1);
         read_word(uart_addr(soc_map_pkg::UART_DIV), rd_val);
         r = $random(seed);
         read_word({1'b0, r[14:2], 2'b00}, rd_val);
      end
      write_word(uart_addr(soc_map_pkg::UART_DIV), {16'h0, DIV_RESET}, '1);
      finish_test("divisor");

      repeat (6) begin
         r = $random(seed);
         write_word(uart_addr(soc_map_pkg::UART_TXDATA), {24'h0, r[7:0]}, '1);
         wait_rx_valid();
         read_word(uart_addr(soc_map_pkg::UART_RXDATA), rd_val);
         read_word(uart_addr(soc_map_pkg::UART_STATUS), rd_val);
      end
      finish_test("loopback");

      for (int i = 0; i < 3; i++) begin
         r = $random(seed);
         fc_bytes[i] = r[7:0];
      end
      write_word(uart_addr(soc_map_pkg::UART_TXDATA), {24'h0, fc_bytes[0]}, '1);
      write_word(uart_addr(soc_map_pkg::UART_TXDATA), {24'h0, fc_bytes[1]}, '1);
      wait_rx_valid();
      // second byte must sit in the holding register while cts is low
      repeat (3 * FRAME_CYCLES) @(posedge clk);
      read_word(uart_addr(soc_map_pkg::UART_STATUS), rd_val);
      read_word(uart_addr(soc_map_pkg::UART_RXDATA), rd_val);
      write_word(uart_addr(soc_map_pkg::UART_TXDATA), {24'h0, fc_bytes[2]}, '1);
      read_word(uart_addr(soc_map_pkg::UART_STATUS), rd_val);
      wait_rx_valid();
      read_word(uart_addr(soc_map_pkg::UART_RXDATA), rd_val);
      wait_rx_valid();
      read_word(uart_addr(soc_map_pkg::UART_RXDATA), rd_val);
      read_word(uart_addr(soc_map_pkg::UART_STATUS), rd_val);
      finish_test("flow control");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, chk.check_count, total_errors());
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: soc_uart.f
src/soc_bus_pkg.sv
src/soc_map_pkg.sv
src/bus_split.sv
src/int_mem.sv
src/uart_core.sv
src/soc_system.sv
tests/soc_system_sva.sv
tests/soc_checker.sv
tests/tb_soc_system.sv

// File: Makefile
# Verilator flow for the soc_uart project

VERILATOR ?= verilator
TOP       ?= tb_soc_system
FILELIST  ?= soc_uart.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run itself may stop early, the log decides the result
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
